// ==== verilog/soundPkg.sv ====
`default_nettype none

package soundPkg;

	// voices per bank, one per distinct sound
	localparam int numSounds = 4;

	localparam int sampleW = 6;
	localparam int addrW = 5;

	// eight full-scale voices fit without overflow
	localparam int mixW = 9;

	// clocks per sample-rate tick, kept short for simulation
	localparam int tickDiv = 8;

	// pattern length and advances per step
	localparam int seqSteps = 8;
	localparam int stepTicks = 4;

	typedef logic [sampleW-1:0] sampleT;
	typedef logic [addrW-1:0] addrT;
	typedef logic [numSounds-1:0] padsT;
	typedef logic [mixW-1:0] mixT;

	// counters for the tick divider and the sequencer
	typedef logic [$clog2(tickDiv)-1:0] tickT;
	typedef logic [$clog2(seqSteps)-1:0] stepT;
	typedef logic [$clog2(stepTicks)-1:0] stepTickT;

	// sample count of each sound
	localparam addrT soundDepth [numSounds] = '{
		addrT'(12),
		addrT'(16),
		addrT'(20),
		addrT'(24)
	};

	// computed stand-in for the sound ROMs
	function automatic sampleT soundSample(
		input int unsigned soundIdx,
		input addrT addr
	);
		int unsigned product;

		product = 32'(addr) * (soundIdx + 32'd1);
		return sampleT'(product);
	endfunction

endpackage

`default_nettype wire

// ==== verilog/voiceIf.sv ====
`timescale 1ns/100ps
`default_nettype none

interface voiceIf;
	import soundPkg::*;

	// strobe from the mixer, one cycle per frame
	logic advance;

	// bank state after each advance
	padsT playing;
	sampleT samples [numSounds];
	logic frameValid;

	modport mixer (
		output advance,
		input playing,
		input samples,
		input frameValid
	);

	modport bank (
		input advance,
		output playing,
		output samples,
		output frameValid
	);

endinterface

`default_nettype wire

// ==== verilog/voiceBank.sv ====
`timescale 1ns/100ps
`default_nettype none

module voiceBank (
	input wire logic clock,
	input wire logic arstN,
	input wire soundPkg::padsT triggers,
	voiceIf.bank bus
);
	import soundPkg::*;

	padsT active;
	padsT nextActive;
	addrT addr [numSounds];
	addrT nextAddr [numSounds];
	sampleT sampleQ [numSounds];
	logic frameValidQ;

	// per-voice start, step and stop
	always_comb begin
		for (int i = 0; i < numSounds; i++) begin
			nextActive[i] = active[i];
			nextAddr[i] = addr[i];
			if (!active[i]) begin
				// idle voice waits for its trigger
				nextActive[i] = triggers[i];
				nextAddr[i] = '0;
			end else if (addr[i] < soundDepth[i] - addrT'(1)) begin
				nextAddr[i] = addr[i] + addrT'(1);
			end else begin
				// last sample was played
				nextActive[i] = 1'b0;
			end
		end
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			active <= '0;
			for (int i = 0; i < numSounds; i++) begin
				addr[i] <= '0;
			end
		end else if (bus.advance) begin
			active <= nextActive;
			for (int i = 0; i < numSounds; i++) begin
				addr[i] <= nextAddr[i];
			end
		end
	end

	// sample lookup for the new address
	always_ff @(posedge clock) begin
		if (bus.advance) begin
			for (int i = 0; i < numSounds; i++) begin
				sampleQ[i] <= nextActive[i] ? soundSample(i, nextAddr[i]) : '0;
			end
		end
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			frameValidQ <= 1'b0;
		end else begin
			frameValidQ <= bus.advance;
		end
	end

	assign bus.playing = active;
	assign bus.samples = sampleQ;
	assign bus.frameValid = frameValidQ;

endmodule

`default_nettype wire

// ==== verilog/stepSequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module stepSequencer (
	input wire logic clock,
	input wire logic arstN,
	input wire logic advance,
	input wire soundPkg::padsT pads,
	input wire logic record,
	input wire logic play,
	output soundPkg::padsT triggers
);
	import soundPkg::*;

	padsT pattern [seqSteps];
	stepT stepPos;
	stepTickT stepTickCnt;
	logic stepDone;

	assign stepDone = (stepTickCnt == stepTickT'(stepTicks - 1));

	// advances within the current step
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			stepTickCnt <= '0;
		end else if (advance) begin
			if (stepDone) begin
				stepTickCnt <= '0;
			end else begin
				stepTickCnt <= stepTickCnt + stepTickT'(1);
			end
		end
	end

	// step position, wraps at the end of the pattern
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			stepPos <= '0;
		end else if (advance && stepDone) begin
			if (stepPos == stepT'(seqSteps - 1)) begin
				stepPos <= '0;
			end else begin
				stepPos <= stepPos + stepT'(1);
			end
		end
	end

	// recording adds pads, never removes them
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			for (int s = 0; s < seqSteps; s++) begin
				pattern[s] <= '0;
			end
		end else if (advance && record) begin
			pattern[stepPos] <= pattern[stepPos] | pads;
		end
	end

	// bank samples this at the advance edge
	assign triggers = play ? pattern[stepPos] : '0;

endmodule

`default_nettype wire

// ==== verilog/voiceMixer.sv ====
`timescale 1ns/100ps
`default_nettype none

module voiceMixer (
	input wire logic clock,
	input wire logic arstN,
	input wire logic sampleAck,
	voiceIf.mixer liveBus,
	voiceIf.mixer seqBus,
	output soundPkg::mixT sampleOut,
	output logic sampleReq,
	output logic advance
);
	import soundPkg::*;

	typedef enum logic [1:0] {
		hsIdle,
		hsFrame,
		hsReq,
		hsDrop
	} hsStateT;

	hsStateT hsState;
	tickT tickCnt;
	logic tickNow;
	logic tickPending;
	logic issue;
	logic frameIn;
	mixT mixSum;

	// sample-rate tick divider
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			tickCnt <= '0;
		end else if (tickNow) begin
			tickCnt <= '0;
		end else begin
			tickCnt <= tickCnt + tickT'(1);
		end
	end

	assign tickNow = (tickCnt == tickT'(tickDiv - 1));

	// a frame may only start with the handshake fully idle
	assign issue = (hsState == hsIdle) && (tickNow || tickPending);

	// one tick held while a frame is in flight
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			tickPending <= 1'b0;
		end else if (issue) begin
			tickPending <= 1'b0;
		end else if (tickNow) begin
			tickPending <= 1'b1;
		end
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			advance <= 1'b0;
		end else begin
			advance <= issue;
		end
	end

	assign liveBus.advance = advance;
	assign seqBus.advance = advance;

	// both banks see the same advance
	assign frameIn = liveBus.frameValid && seqBus.frameValid;

	always_comb begin
		mixSum = '0;
		for (int i = 0; i < numSounds; i++) begin
			if (liveBus.playing[i]) begin
				mixSum = mixSum + mixT'(liveBus.samples[i]);
			end
			if (seqBus.playing[i]) begin
				mixSum = mixSum + mixT'(seqBus.samples[i]);
			end
		end
	end

	// four-phase req/ack
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			hsState <= hsIdle;
		end else begin
			case (hsState)
				hsIdle: begin
					if (issue) begin
						hsState <= hsFrame;
					end
				end
				hsFrame: begin
					if (frameIn) begin
						hsState <= hsReq;
					end
				end
				hsReq: begin
					if (sampleAck) begin
						hsState <= hsDrop;
					end
				end
				hsDrop: begin
					// consumer must release ack first
					if (!sampleAck) begin
						hsState <= hsIdle;
					end
				end
				default: begin
					hsState <= hsIdle;
				end
			endcase
		end
	end

	// held stable for the whole request
	always_ff @(posedge clock) begin
		if (frameIn) begin
			sampleOut <= mixSum;
		end
	end

	assign sampleReq = (hsState == hsReq);

endmodule

`default_nettype wire

// ==== verilog/soundPlayer.sv ====
`timescale 1ns/100ps
`default_nettype none

module soundPlayer (
	input wire logic clock,
	input wire logic arstN,
	input wire soundPkg::padsT pads,
	input wire logic record,
	input wire logic play,
	input wire logic sampleAck,
	output soundPkg::mixT sampleOut,
	output logic sampleReq
);
	import soundPkg::*;

	logic advance;
	padsT seqTriggers;

	voiceIf liveBus ();
	voiceIf seqBus ();

	// pads drive the live voices directly
	voiceBank liveBank (
		.clock(clock),
		.arstN(arstN),
		.triggers(pads),
		.bus(liveBus)
	);

	// pattern playback
	stepSequencer sequencer (
		.clock(clock),
		.arstN(arstN),
		.advance(advance),
		.pads(pads),
		.record(record),
		.play(play),
		.triggers(seqTriggers)
	);

	voiceBank seqBank (
		.clock(clock),
		.arstN(arstN),
		.triggers(seqTriggers),
		.bus(seqBus)
	);

	// sum of both banks, out through req/ack
	voiceMixer mixer (
		.clock(clock),
		.arstN(arstN),
		.sampleAck(sampleAck),
		.liveBus(liveBus),
		.seqBus(seqBus),
		.sampleOut(sampleOut),
		.sampleReq(sampleReq),
		.advance(advance)
	);

endmodule

`default_nettype wire

// ==== tb/soundModel.svh ====
localparam int modelDepth [numSounds] = '{12, 16, 20, 24};

// bank 0 is the live bank and bank 1 the sequenced bank
logic modelOn [2][numSounds];
int modelAddr [2][numSounds];
padsT modelPattern [seqSteps];
int modelStep;
int modelStepTick;
int unsigned lcgState = 17371;

function automatic int expectedSample(int soundIdx, int addr);
	return (addr * (soundIdx + 1)) % (1 << sampleW);
endfunction

function automatic void modelReset();
	for (int b = 0; b < 2; b++) begin
		for (int i = 0; i < numSounds; i++) begin
			modelOn[b][i] = 1'b0;
			modelAddr[b][i] = 0;
		end
	end
	for (int s = 0; s < seqSteps; s++) begin
		modelPattern[s] = '0;
	end
	modelStep = 0;
	modelStepTick = 0;
endfunction

// steps one bank and returns the sum of its voices
function automatic int bankAdvance(int bank, padsT trig);
	int sum;
	sum = 0;
	for (int i = 0; i < numSounds; i++) begin
		if (!modelOn[bank][i]) begin
			modelOn[bank][i] = trig[i];
			modelAddr[bank][i] = 0;
		end else if (modelAddr[bank][i] < modelDepth[i] - 1) begin
			modelAddr[bank][i]++;
		end else begin
			modelOn[bank][i] = 1'b0;
		end
		if (modelOn[bank][i]) begin
			sum += expectedSample(i, modelAddr[bank][i]);
		end
	end
	return sum;
endfunction

function automatic int modelFrame(padsT padsIn, logic recordIn, logic playIn);
	padsT seqTrig;
	int sum;
	// pattern as it stood before this advance
	seqTrig = playIn ? modelPattern[modelStep] : '0;
	sum = bankAdvance(0, padsIn) + bankAdvance(1, seqTrig);
	if (recordIn) begin
		modelPattern[modelStep] = modelPattern[modelStep] | padsIn;
	end
	if (modelStepTick == stepTicks - 1) begin
		modelStepTick = 0;
		modelStep = (modelStep + 1) % seqSteps;
	end else begin
		modelStepTick++;
	end
	return sum;
endfunction

function automatic int unsigned nextRandom();
	lcgState = lcgState * 32'd1103515245 + 32'd12345;
	return (lcgState >> 16) & 32'h7fff;
endfunction

// ==== tb/soundPlayerTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module soundPlayerTb;
	import soundPkg::*;

	localparam int clockPeriod = 40;
	localparam int waitLimit = 200;

	logic clock = 1'b0;
	logic arstN;
	padsT pads;
	logic record;
	logic play;
	logic sampleAck;
	mixT sampleOut;
	logic sampleReq;

	// inputs the DUT takes at the next advance
	padsT curPads;
	logic curRecord;
	logic curPlay;

	int checkCount = 0;
	int errorCount = 0;
	int frameCount = 0;

	`include "soundModel.svh"

	soundPlayer dut_i (
		.clock(clock),
		.arstN(arstN),
		.pads(pads),
		.record(record),
		.play(play),
		.sampleAck(sampleAck),
		.sampleOut(sampleOut),
		.sampleReq(sampleReq)
	);

	always #(clockPeriod / 2) clock = ~clock;

	task automatic waitReq(input logic level);
		int cycles;
		cycles = 0;
		@(negedge clock);
		while (sampleReq !== level && cycles < waitLimit) begin
			@(negedge clock);
			cycles++;
		end
		if (sampleReq !== level) begin
			$display("timeout: sampleReq did not go %s within %0d cycles",
				level ? "high" : "low", waitLimit);
			$display("RESULT: FAIL");
			$finish;
		end
	endtask

	// check one frame, then load the inputs for the next one and ack
	task automatic serviceFrame(input string testName, input padsT nextPads,
		input logic nextRecord, input logic nextPlay, input int ackDelay);
		int expected;
		expected = modelFrame(curPads, curRecord, curPlay);
		waitReq(1'b1);
		checkCount++;
		if (sampleOut !== mixT'(expected)) begin
			errorCount++;
			$display("CHECK FAILED %s frame %0d: expected %0d, actual %0d",
				testName, frameCount, expected, sampleOut);
		end
		frameCount++;
		@(posedge clock);
		pads <= nextPads;
		record <= nextRecord;
		play <= nextPlay;
		curPads = nextPads;
		curRecord = nextRecord;
		curPlay = nextPlay;
		repeat (ackDelay) @(posedge clock);
		sampleAck <= 1'b1;
		waitReq(1'b0);
		@(posedge clock);
		sampleAck <= 1'b0;
	endtask

	task automatic runQuiet(input string testName, input int frames, input logic playOn);
		for (int n = 0; n < frames; n++) begin
			serviceFrame(testName, '0, 1'b0, playOn, 0);
		end
	endtask

	task automatic reportTest(input string testName, input int errorsBefore);
		$display("test %s finished with %0d errors", testName, errorCount - errorsBefore);
	endtask

	task automatic testAfterReset();
		int errorsBefore;
		errorsBefore = errorCount;
		@(negedge clock);
		checkCount++;
		if (sampleReq !== 1'b0) begin
			errorCount++;
			$display("CHECK FAILED afterReset sampleReq: expected 0, actual %0b", sampleReq);
		end
		runQuiet("afterReset", 6, 1'b0);
		reportTest("afterReset", errorsBefore);
	endtask

	task automatic testSinglePad();
		int errorsBefore;
		errorsBefore = errorCount;
		serviceFrame("singlePad", 4'b0100, 1'b0, 1'b0, 0);
		runQuiet("singlePad", 24, 1'b0);
		reportTest("singlePad", errorsBefore);
	endtask

	task automatic testOverlap();
		int errorsBefore;
		errorsBefore = errorCount;
		serviceFrame("overlap", 4'b0001, 1'b0, 1'b0, 0);
		runQuiet("overlap", 3, 1'b0);
		serviceFrame("overlap", 4'b1000, 1'b0, 1'b0, 0);
		runQuiet("overlap", 2, 1'b0);
		// both voices still busy, so these presses change nothing
		serviceFrame("overlap", 4'b0001, 1'b0, 1'b0, 0);
		serviceFrame("overlap", 4'b1000, 1'b0, 1'b0, 0);
		runQuiet("overlap", 26, 1'b0);
		reportTest("overlap", errorsBefore);
	endtask

	task automatic testRecordPlay();
		int errorsBefore;
		errorsBefore = errorCount;
		for (int n = 0; n < stepTicks; n++) begin
			serviceFrame("recordPlay", 4'b0010, 1'b1, 1'b0, 0);
		end
		runQuiet("recordPlay", 40, 1'b1);
		runQuiet("recordPlay", 30, 1'b0);
		reportTest("recordPlay", errorsBefore);
	endtask

	task automatic testBackPressure();
		int errorsBefore;
		int unsigned r;
		padsT nextPads;
		int delay;
		errorsBefore = errorCount;
		for (int n = 0; n < 200; n++) begin
			r = nextRandom();
			nextPads = ((r >> 5) % 8 == 0) ? padsT'(r) : '0;
			delay = ((r >> 13) % 2 == 0) ? 0 : int'(nextRandom() % 7);
			serviceFrame("backPressure", nextPads, (r >> 8) % 4 == 0,
				(r >> 10) % 8 != 0, delay);
		end
		reportTest("backPressure", errorsBefore);
	endtask

	initial begin
		arstN = 1'b0;
		pads = '0;
		record = 1'b0;
		play = 1'b0;
		sampleAck = 1'b0;
		curPads = '0;
		curRecord = 1'b0;
		curPlay = 1'b0;
		modelReset();
		repeat (10) @(posedge clock);
		arstN <= 1'b1;
		testAfterReset();
		testSinglePad();
		testOverlap();
		testRecordPlay();
		testBackPressure();
		$display("checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+tb
verilog/soundPkg.sv
verilog/voiceIf.sv
verilog/voiceBank.sv
verilog/stepSequencer.sv
verilog/voiceMixer.sv
verilog/soundPlayer.sv
tb/soundPlayerTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS = --binary --timing -Wno-fatal
TOP = soundPlayerTb
FILELIST = list.f
BUILD = obj_dir
BIN = $(BUILD)/V$(TOP)
LOG = sim.log
SOURCES = $(shell grep -v '^+' $(FILELIST))
HEADERS = tb/soundModel.svh

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
